//--- logic/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// datapath and instruction widths
`define DATA_WIDTH      32
`define INST_WIDTH      32

// register file geometry
`define REG_ADDR_WIDTH  5
`define REG_COUNT       32

// instruction fields
`define IMM_WIDTH       16
`define SHAMT_WIDTH     5

`endif

//--- logic/isa_pkg.sv
`default_nettype none

`include "decode_config.svh"

package isa_pkg;

    typedef logic [`INST_WIDTH-1:0]  inst_t;
    typedef logic [5:0]              opcode_t;
    typedef logic [5:0]              funct_t;
    typedef logic [`SHAMT_WIDTH-1:0] shamt_t;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;

    // function field under SPECIAL
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

endpackage

`default_nettype wire

//--- logic/pipe_pkg.sv
`default_nettype none

`include "decode_config.svh"

package pipe_pkg;

    typedef logic [`DATA_WIDTH-1:0]     word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [7:0]                 aluop_t;
    typedef logic [2:0]                 alusel_t;

    // alu operations
    localparam aluop_t ALU_NOP   = 8'b00000000;
    localparam aluop_t ALU_SRL   = 8'b00000010;
    localparam aluop_t ALU_SRA   = 8'b00000011;
    localparam aluop_t ALU_ADD   = 8'b00100000;
    localparam aluop_t ALU_ADDU  = 8'b00100001;
    localparam aluop_t ALU_SUB   = 8'b00100010;
    localparam aluop_t ALU_SUBU  = 8'b00100011;
    localparam aluop_t ALU_AND   = 8'b00100100;
    localparam aluop_t ALU_OR    = 8'b00100101;
    localparam aluop_t ALU_XOR   = 8'b00100110;
    localparam aluop_t ALU_NOR   = 8'b00100111;
    localparam aluop_t ALU_SLT   = 8'b00101010;
    localparam aluop_t ALU_SLTU  = 8'b00101011;
    localparam aluop_t ALU_ADDI  = 8'b01010101;
    localparam aluop_t ALU_ADDIU = 8'b01010110;
    localparam aluop_t ALU_SLL   = 8'b01111100;

    // result group seen by execute
    localparam alusel_t RES_NOP   = 3'b000;
    localparam alusel_t RES_LOGIC = 3'b001;
    localparam alusel_t RES_SHIFT = 3'b010;
    localparam alusel_t RES_ARITH = 3'b100;

endpackage

`default_nettype wire

//--- logic/stage_ifs.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

// source operand request from the decoder
interface operand_if import pipe_pkg::*; ();

    logic      src1_read;
    logic      src2_read;
    reg_addr_t src1_addr;
    reg_addr_t src2_addr;
    word_t     imm;

    modport decoder (output src1_read, src2_read, src1_addr, src2_addr, imm);
    modport regfile (input src1_addr, src2_addr);
    modport select  (input src1_read, src2_read, src1_addr, src2_addr, imm);

endinterface

// results still in flight in execute and memory
interface bypass_if import pipe_pkg::*; ();

    logic      ex_wreg;
    reg_addr_t ex_dest_addr;
    word_t     ex_dest_data;
    logic      mem_wreg;
    reg_addr_t mem_dest_addr;
    word_t     mem_dest_data;

    modport select (
        input ex_wreg, ex_dest_addr, ex_dest_data,
        input mem_wreg, mem_dest_addr, mem_dest_data
    );

endinterface

`default_nettype wire

//--- logic/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module inst_decoder
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  inst_t             inst,
    operand_if.decoder        ops,
    output aluop_t            aluop,
    output alusel_t           alusel,
    output reg_addr_t         dest_addr,
    output logic              wreg,
    output logic              illegal
);

    opcode_t                opcode;
    reg_addr_t              rs;
    reg_addr_t              rt;
    reg_addr_t              rd;
    shamt_t                 shamt;
    funct_t                 funct;
    logic [`IMM_WIDTH-1:0]  imm16;

    // which operand layout the instruction uses
    logic  fmt_reg;
    logic  fmt_shift;
    logic  fmt_imm;
    word_t imm_val;

    assign opcode = inst[31:26];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign shamt  = inst[10:6];
    assign funct  = inst[5:0];
    assign imm16  = inst[`IMM_WIDTH-1:0];

    always_comb begin
        aluop     = ALU_NOP;
        alusel    = RES_NOP;
        fmt_reg   = 1'b0;
        fmt_shift = 1'b0;
        fmt_imm   = 1'b0;
        imm_val   = '0;

        // three-register forms need sa == 0
        if (opcode == OP_SPECIAL && shamt == '0) begin
            fmt_reg = 1'b1;
            alusel  = RES_ARITH;
            case (funct)
                FN_AND:  aluop = ALU_AND;
                FN_OR:   aluop = ALU_OR;
                FN_XOR:  aluop = ALU_XOR;
                FN_NOR:  aluop = ALU_NOR;
                FN_SLLV: aluop = ALU_SLL;
                FN_SRLV: aluop = ALU_SRL;
                FN_SRAV: aluop = ALU_SRA;
                FN_SLT:  aluop = ALU_SLT;
                FN_SLTU: aluop = ALU_SLTU;
                FN_ADD:  aluop = ALU_ADD;
                FN_ADDU: aluop = ALU_ADDU;
                FN_SUB:  aluop = ALU_SUB;
                FN_SUBU: aluop = ALU_SUBU;
                default: begin
                    fmt_reg = 1'b0;
                    alusel  = RES_NOP;
                end
            endcase
            case (funct)
                FN_AND, FN_OR, FN_XOR, FN_NOR: alusel = RES_LOGIC;
                FN_SLLV, FN_SRLV, FN_SRAV:     alusel = RES_SHIFT;
                default: ;
            endcase
        end

        // constant shifts, rs and opcode all zero
        if (inst[31:21] == '0) begin
            case (funct)
                FN_SLL: aluop = ALU_SLL;
                FN_SRL: aluop = ALU_SRL;
                FN_SRA: aluop = ALU_SRA;
                default: ;
            endcase
            if (funct == FN_SLL || funct == FN_SRL || funct == FN_SRA) begin
                fmt_shift = 1'b1;
                alusel    = RES_SHIFT;
                imm_val   = {{(`DATA_WIDTH-`SHAMT_WIDTH){1'b0}}, shamt};
            end
        end

        case (opcode)
            OP_ANDI, OP_ORI, OP_XORI: begin
                fmt_imm = 1'b1;
                alusel  = RES_LOGIC;
                imm_val = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, imm16};
                if (opcode == OP_ANDI) begin
                    aluop = ALU_AND;
                end else if (opcode == OP_ORI) begin
                    aluop = ALU_OR;
                end else begin
                    aluop = ALU_XOR;
                end
            end
            OP_LUI: begin
                // or with upper-half constant
                fmt_imm = 1'b1;
                aluop   = ALU_OR;
                alusel  = RES_LOGIC;
                imm_val = {imm16, {(`DATA_WIDTH-`IMM_WIDTH){1'b0}}};
            end
            OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU: begin
                fmt_imm = 1'b1;
                alusel  = RES_ARITH;
                imm_val = {{(`DATA_WIDTH-`IMM_WIDTH){imm16[`IMM_WIDTH-1]}}, imm16};
                case (opcode)
                    OP_SLTI:  aluop = ALU_SLT;
                    OP_SLTIU: aluop = ALU_SLTU;
                    OP_ADDI:  aluop = ALU_ADDI;
                    default:  aluop = ALU_ADDIU;
                endcase
            end
            default: ;
        endcase
    end

    assign illegal = !(fmt_reg || fmt_shift || fmt_imm);
    assign wreg    = !illegal;

    // immediate forms write rt, everything else rd
    assign dest_addr = fmt_imm ? rt : rd;

    assign ops.src1_read = fmt_reg || fmt_imm;
    assign ops.src2_read = fmt_reg || fmt_shift;
    assign ops.src1_addr = rs;
    assign ops.src2_addr = rt;
    assign ops.imm       = imm_val;

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module reg_file
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    operand_if.regfile ops,
    input  logic       we,
    input  reg_addr_t  waddr,
    input  word_t      wdata,
    output word_t      rdata1,
    output word_t      rdata2
);

    word_t regs [`REG_COUNT];

    // r0 is never written so it stays at its reset zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // async reads, old value during a same-cycle write
    assign rdata1 = regs[ops.src1_addr];
    assign rdata2 = regs[ops.src2_addr];

endmodule

`default_nettype wire

//--- logic/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module operand_select
    import pipe_pkg::*;
(
    operand_if.select ops,
    bypass_if.select  byp,
    input  word_t     rdata1,
    input  word_t     rdata2,
    output word_t     src1,
    output word_t     src2
);

    // ex bypass first, then mem, then the register file
    function automatic word_t pick_operand(
        input logic      rd,
        input reg_addr_t addr,
        input word_t     rf_data,
        input word_t     imm,
        input logic      ex_wreg,
        input reg_addr_t ex_addr,
        input word_t     ex_data,
        input logic      mem_wreg,
        input reg_addr_t mem_addr,
        input word_t     mem_data
    );
        if (!rd) begin
            return imm;
        end else if (ex_wreg && ex_addr == addr) begin
            return ex_data;
        end else if (mem_wreg && mem_addr == addr) begin
            return mem_data;
        end
        return rf_data;
    endfunction

    // r0 is bypassed like any other register
    assign src1 = pick_operand(ops.src1_read, ops.src1_addr, rdata1, ops.imm,
                               byp.ex_wreg, byp.ex_dest_addr, byp.ex_dest_data,
                               byp.mem_wreg, byp.mem_dest_addr, byp.mem_dest_data);

    assign src2 = pick_operand(ops.src2_read, ops.src2_addr, rdata2, ops.imm,
                               byp.ex_wreg, byp.ex_dest_addr, byp.ex_dest_data,
                               byp.mem_wreg, byp.mem_dest_addr, byp.mem_dest_data);

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      inst_valid,
    input  inst_t     inst,

    input  logic      wb_we,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,

    // forwarding from execute and memory
    input  logic      fwd_ex_wreg,
    input  reg_addr_t fwd_ex_dest_addr,
    input  word_t     fwd_ex_dest_data,
    input  logic      fwd_mem_wreg,
    input  reg_addr_t fwd_mem_dest_addr,
    input  word_t     fwd_mem_dest_data,

    output logic      ex_valid,
    output logic      ex_illegal,
    output aluop_t    ex_aluop,
    output alusel_t   ex_alusel,
    output word_t     ex_src1,
    output word_t     ex_src2,
    output reg_addr_t ex_dest_addr,
    output logic      ex_wreg
);

    operand_if ops_if ();
    bypass_if  byp_if ();

    aluop_t    dec_aluop;
    alusel_t   dec_alusel;
    reg_addr_t dec_dest_addr;
    logic      dec_wreg;
    logic      dec_illegal;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     sel_src1;
    word_t     sel_src2;

    assign byp_if.ex_wreg       = fwd_ex_wreg;
    assign byp_if.ex_dest_addr  = fwd_ex_dest_addr;
    assign byp_if.ex_dest_data  = fwd_ex_dest_data;
    assign byp_if.mem_wreg      = fwd_mem_wreg;
    assign byp_if.mem_dest_addr = fwd_mem_dest_addr;
    assign byp_if.mem_dest_data = fwd_mem_dest_data;

    inst_decoder inst_decoder_i (
        .inst      (inst),
        .ops       (ops_if.decoder),
        .aluop     (dec_aluop),
        .alusel    (dec_alusel),
        .dest_addr (dec_dest_addr),
        .wreg      (dec_wreg),
        .illegal   (dec_illegal)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .ops    (ops_if.regfile),
        .we     (wb_we),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    operand_select operand_select_i (
        .ops    (ops_if.select),
        .byp    (byp_if.select),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .src1   (sel_src1),
        .src2   (sel_src2)
    );

    // stage register toward execute, loads on the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_illegal   <= 1'b0;
            ex_aluop     <= ALU_NOP;
            ex_alusel    <= RES_NOP;
            ex_src1      <= '0;
            ex_src2      <= '0;
            ex_dest_addr <= '0;
            ex_wreg      <= 1'b0;
        end else begin
            ex_valid <= inst_valid;
            if (inst_valid) begin
                ex_illegal   <= dec_illegal;
                ex_aluop     <= dec_aluop;
                ex_alusel    <= dec_alusel;
                ex_src1      <= sel_src1;
                ex_src2      <= sel_src2;
                ex_dest_addr <= dec_dest_addr;
                ex_wreg      <= dec_wreg;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/decode_checker.sv
`timescale 1ns/1ps
`default_nettype none

module decode_checker
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       exp_push,
    input  logic [1:0] exp_kind,
    input  logic       exp_illegal,
    input  aluop_t     exp_aluop,
    input  alusel_t    exp_alusel,
    input  word_t      exp_src1,
    input  word_t      exp_src2,
    input  reg_addr_t  exp_dest_addr,
    input  logic       exp_wreg,
    input  logic       ex_valid,
    input  logic       ex_illegal,
    input  aluop_t     ex_aluop,
    input  alusel_t    ex_alusel,
    input  word_t      ex_src1,
    input  word_t      ex_src2,
    input  reg_addr_t  ex_dest_addr,
    input  logic       ex_wreg,
    output int         n_checked,
    output int         n_errors
);

    typedef struct packed {
        logic [1:0] kind;
        logic       illegal;
        aluop_t     aluop;
        alusel_t    alusel;
        word_t      src1;
        word_t      src2;
        reg_addr_t  dest_addr;
        logic       wreg;
    } result_t;

    result_t pending [$];
    result_t head;
    logic    seen_strobe = 1'b0;
    int      checked = 0;
    int      errors = 0;

    assign n_checked = checked;
    assign n_errors  = errors;

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            2'd0:    return "rtype";
            2'd1:    return "imm";
            2'd2:    return "shift";
            default: return "illegal";
        endcase
    endfunction

    task automatic compare(input string test, input string field,
                           input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s.%s expected %08h actual %08h", test, field, expected, actual);
            errors++;
        end
    endtask

    task automatic check_result(input result_t e);
        string test;
        test = kind_name(e.kind);
        compare(test, "illegal", 32'(e.illegal), 32'(ex_illegal));
        compare(test, "wreg", 32'(e.wreg), 32'(ex_wreg));
        compare(test, "aluop", 32'(e.aluop), 32'(ex_aluop));
        // an illegal word leaves the rest undefined
        if (!e.illegal) begin
            compare(test, "alusel", 32'(e.alusel), 32'(ex_alusel));
            compare(test, "src1", e.src1, ex_src1);
            compare(test, "src2", e.src2, ex_src2);
            compare(test, "dest_addr", 32'(e.dest_addr), 32'(ex_dest_addr));
        end
    endtask

    // mid-cycle sampling, DUT outputs and expectations are both settled
    always @(negedge clk) begin
        if (exp_push) begin
            pending.push_back(result_t'({exp_kind, exp_illegal, exp_aluop, exp_alusel,
                                         exp_src1, exp_src2, exp_dest_addr, exp_wreg}));
            seen_strobe = 1'b1;
        end
        if (!seen_strobe) begin
            if (ex_valid || ex_illegal || ex_wreg || ex_aluop != ALU_NOP ||
                ex_alusel != RES_NOP || ex_src1 != '0 || ex_src2 != '0 ||
                ex_dest_addr != '0) begin
                $display("outputs left their reset values before the first instruction");
                errors++;
            end
        end else if (ex_valid) begin
            if (pending.size() == 0) begin
                $display("ex_valid was raised with no instruction waiting for it");
                errors++;
            end else begin
                head = pending.pop_front();
                check_result(head);
                checked++;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module tb_decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int NUM_INSTS   = 2000;
    localparam int CYCLE_LIMIT = 3 * NUM_INSTS + 200;

    localparam logic [1:0] KIND_RTYPE   = 2'd0;
    localparam logic [1:0] KIND_IMM     = 2'd1;
    localparam logic [1:0] KIND_SHIFT   = 2'd2;
    localparam logic [1:0] KIND_ILLEGAL = 2'd3;

    localparam funct_t R_FUNCTS [13] = '{FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLLV, FN_SRLV,
        FN_SRAV, FN_SLT, FN_SLTU, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU};
    localparam funct_t S_FUNCTS [3] = '{FN_SLL, FN_SRL, FN_SRA};
    localparam opcode_t I_OPS [8] = '{OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU};

    typedef struct packed {
        logic [1:0] kind;
        logic       illegal;
        aluop_t     aluop;
        alusel_t    alusel;
        word_t      src1;
        word_t      src2;
        reg_addr_t  dest_addr;
        logic       wreg;
    } result_t;

    logic      clk;
    logic      rst_n;
    logic      inst_valid;
    inst_t     inst;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      fwd_ex_wreg;
    reg_addr_t fwd_ex_dest_addr;
    word_t     fwd_ex_dest_data;
    logic      fwd_mem_wreg;
    reg_addr_t fwd_mem_dest_addr;
    word_t     fwd_mem_dest_data;
    logic      ex_valid;
    logic      ex_illegal;
    aluop_t    ex_aluop;
    alusel_t   ex_alusel;
    word_t     ex_src1;
    word_t     ex_src2;
    reg_addr_t ex_dest_addr;
    logic      ex_wreg;

    result_t   pred;
    logic      pred_valid;
    result_t   exp_res;
    logic      exp_push;
    int        n_checked;
    int        n_errors;
    word_t     model_regs [`REG_COUNT];
    int        sent;
    int        cycles;

    decode_stage decode_stage_i (.*);

    decode_checker decode_checker_i (
        .clk           (clk),
        .exp_push      (exp_push),
        .exp_kind      (exp_res.kind),
        .exp_illegal   (exp_res.illegal),
        .exp_aluop     (exp_res.aluop),
        .exp_alusel    (exp_res.alusel),
        .exp_src1      (exp_res.src1),
        .exp_src2      (exp_res.src2),
        .exp_dest_addr (exp_res.dest_addr),
        .exp_wreg      (exp_res.wreg),
        .ex_valid      (ex_valid),
        .ex_illegal    (ex_illegal),
        .ex_aluop      (ex_aluop),
        .ex_alusel     (ex_alusel),
        .ex_src1       (ex_src1),
        .ex_src2       (ex_src2),
        .ex_dest_addr  (ex_dest_addr),
        .ex_wreg       (ex_wreg),
        .n_checked     (n_checked),
        .n_errors      (n_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // small register numbers half the time so bypass hits are common
    function automatic reg_addr_t rand_reg();
        return ($urandom % 2 == 1) ? reg_addr_t'($urandom % 8) : reg_addr_t'($urandom);
    endfunction

    function automatic inst_t random_inst();
        int        pick;
        reg_addr_t shift_rs;
        pick = $urandom % 100;
        if (pick < 35) begin
            return {OP_SPECIAL, rand_reg(), rand_reg(), rand_reg(), shamt_t'(0),
                    R_FUNCTS[$urandom % 13]};
        end else if (pick < 70) begin
            return {I_OPS[$urandom % 8], rand_reg(), rand_reg(), 16'($urandom)};
        end else if (pick < 90) begin
            // now and then a nonzero rs, which is no constant shift
            shift_rs = ($urandom % 8 == 0) ? rand_reg() : reg_addr_t'(0);
            return {OP_SPECIAL, shift_rs, rand_reg(), rand_reg(), shamt_t'($urandom),
                    S_FUNCTS[$urandom % 3]};
        end else if (pick < 95) begin
            // kept function with a nonzero sa field
            return {OP_SPECIAL, rand_reg(), rand_reg(), rand_reg(),
                    shamt_t'($urandom % 31 + 1), R_FUNCTS[$urandom % 13]};
        end
        return $urandom;
    endfunction

    function automatic word_t operand_value(input reg_addr_t addr);
        if (fwd_ex_wreg && fwd_ex_dest_addr == addr) begin
            return fwd_ex_dest_data;
        end
        if (fwd_mem_wreg && fwd_mem_dest_addr == addr) begin
            return fwd_mem_dest_data;
        end
        return model_regs[addr];
    endfunction

    task automatic set_op(input aluop_t op, input alusel_t sel);
        pred.aluop  = op;
        pred.alusel = sel;
    endtask

    task automatic set_imm(input aluop_t op, input alusel_t sel, input word_t value);
        set_op(op, sel);
        pred.src2 = value;
    endtask

    task automatic predict(input inst_t w);
        logic [15:0] im;
        im = w[15:0];
        pred = '0;
        pred.wreg = 1'b1;
        pred.dest_addr = w[15:11];
        pred.src1 = operand_value(w[25:21]);
        pred.src2 = operand_value(w[20:16]);
        if (w[31:21] == '0 && w[5:0] inside {FN_SLL, FN_SRL, FN_SRA}) begin
            pred.kind = KIND_SHIFT;
            pred.alusel = RES_SHIFT;
            pred.src1 = word_t'(w[10:6]);
            case (w[5:0])
                FN_SLL:  pred.aluop = ALU_SLL;
                FN_SRL:  pred.aluop = ALU_SRL;
                default: pred.aluop = ALU_SRA;
            endcase
        end else if (w[31:26] == OP_SPECIAL && w[10:6] == '0) begin
            pred.kind = KIND_RTYPE;
            case (w[5:0])
                FN_AND:  set_op(ALU_AND, RES_LOGIC);
                FN_OR:   set_op(ALU_OR, RES_LOGIC);
                FN_XOR:  set_op(ALU_XOR, RES_LOGIC);
                FN_NOR:  set_op(ALU_NOR, RES_LOGIC);
                FN_SLLV: set_op(ALU_SLL, RES_SHIFT);
                FN_SRLV: set_op(ALU_SRL, RES_SHIFT);
                FN_SRAV: set_op(ALU_SRA, RES_SHIFT);
                FN_SLT:  set_op(ALU_SLT, RES_ARITH);
                FN_SLTU: set_op(ALU_SLTU, RES_ARITH);
                FN_ADD:  set_op(ALU_ADD, RES_ARITH);
                FN_ADDU: set_op(ALU_ADDU, RES_ARITH);
                FN_SUB:  set_op(ALU_SUB, RES_ARITH);
                FN_SUBU: set_op(ALU_SUBU, RES_ARITH);
                default: pred.illegal = 1'b1;
            endcase
        end else begin
            pred.kind = KIND_IMM;
            pred.dest_addr = w[20:16];
            case (w[31:26])
                OP_ANDI:  set_imm(ALU_AND, RES_LOGIC, word_t'(im));
                OP_ORI:   set_imm(ALU_OR, RES_LOGIC, word_t'(im));
                OP_XORI:  set_imm(ALU_XOR, RES_LOGIC, word_t'(im));
                OP_LUI:   set_imm(ALU_OR, RES_LOGIC, {im, 16'h0000});
                OP_SLTI:  set_imm(ALU_SLT, RES_ARITH, word_t'($signed(im)));
                OP_SLTIU: set_imm(ALU_SLTU, RES_ARITH, word_t'($signed(im)));
                OP_ADDI:  set_imm(ALU_ADDI, RES_ARITH, word_t'($signed(im)));
                OP_ADDIU: set_imm(ALU_ADDIU, RES_ARITH, word_t'($signed(im)));
                default:  pred.illegal = 1'b1;
            endcase
        end
        if (pred.illegal) begin
            pred.kind  = KIND_ILLEGAL;
            pred.wreg  = 1'b0;
            pred.aluop = ALU_NOP;
        end
    endtask

    // expectation from the previous cycle goes out with the new inputs
    task automatic start_cycle();
        @(posedge clk);
        exp_push <= pred_valid;
        exp_res  <= pred;
    endtask

    task automatic finish_cycle();
        @(negedge clk);
        pred_valid = inst_valid;
        if (inst_valid) begin
            predict(inst);
        end
        // write-back lands on the next edge after this read
        if (wb_we && wb_addr != '0) begin
            model_regs[wb_addr] = wb_data;
        end
    endtask

    initial begin
        int unsigned seed_ret;
        seed_ret = $urandom(25716);
        rst_n             <= 1'b0;
        inst_valid        <= 1'b0;
        inst              <= '0;
        wb_we             <= 1'b0;
        wb_addr           <= '0;
        wb_data           <= '0;
        fwd_ex_wreg       <= 1'b0;
        fwd_ex_dest_addr  <= '0;
        fwd_ex_dest_data  <= '0;
        fwd_mem_wreg      <= 1'b0;
        fwd_mem_dest_addr <= '0;
        fwd_mem_dest_data <= '0;
        exp_push          <= 1'b0;
        exp_res           <= '0;
        pred       = '0;
        pred_valid = 1'b0;
        sent       = 0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // fill every register including r0
        for (int r = 0; r < `REG_COUNT; r++) begin
            start_cycle();
            wb_we   <= 1'b1;
            wb_addr <= reg_addr_t'(r);
            wb_data <= $urandom;
            finish_cycle();
        end

        while (sent < NUM_INSTS) begin
            start_cycle();
            inst_valid        <= ($urandom % 4) != 0;
            inst              <= random_inst();
            wb_we             <= ($urandom % 3) == 0;
            wb_addr           <= rand_reg();
            wb_data           <= $urandom;
            fwd_ex_wreg       <= 1'($urandom);
            fwd_ex_dest_addr  <= rand_reg();
            fwd_ex_dest_data  <= $urandom;
            fwd_mem_wreg      <= 1'($urandom);
            fwd_mem_dest_addr <= rand_reg();
            fwd_mem_dest_data <= $urandom;
            finish_cycle();
            if (inst_valid) begin
                sent++;
            end
        end

        start_cycle();
        inst_valid <= 1'b0;
        wb_we      <= 1'b0;
        finish_cycle();
        while (n_checked < sent) begin
            @(posedge clk);
        end

        $display("checked %0d results, %0d errors", n_checked, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d expected results never came",
                 cycles, sent - n_checked, sent);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/stage_ifs.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/operand_select.sv
logic/decode_stage.sv
test/decode_checker.sv
test/tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_decode_stage \
    -Mdir obj_dir -o tb_decode_stage
./obj_dir/tb_decode_stage > sim.log 2>&1
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    exit 0
fi
exit 1
